/* design/audio_pkg.sv */
`default_nettype none

package audio_pkg;

    // Data bits per channel word
    localparam int SAMPLE_BITS = 24;

    // Slot bit counter, saturates at SAMPLE_BITS once the word is in
    localparam int BIT_CNT_BITS = $clog2(SAMPLE_BITS + 1);

    typedef logic [BIT_CNT_BITS-1:0] bit_cnt_t;

    localparam bit_cnt_t LAST_BIT  = bit_cnt_t'(SAMPLE_BITS - 1);
    localparam bit_cnt_t SLOT_DONE = bit_cnt_t'(SAMPLE_BITS);

    // One signed PCM word
    typedef logic signed [SAMPLE_BITS-1:0] sample_t;

    // Latest word captured for each channel
    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_sample_t;

    // Channel selected by the lrclk level
    typedef enum logic {
        CH_LEFT  = 1'b0,
        CH_RIGHT = 1'b1
    } channel_e;

endpackage

`default_nettype wire

/* design/pwm_pkg.sv */
`default_nettype none

package pwm_pkg;

    // Duty resolution
    localparam int PWM_BITS = 8;

    // clk cycles per PWM period, one per duty step
    localparam int PWM_PERIOD = 1 << PWM_BITS;

    typedef logic [PWM_BITS-1:0] duty_t;

    // Last count before the period counter wraps
    localparam duty_t CNT_LAST = duty_t'(PWM_PERIOD - 1);

    // Idle until the first sample arrives
    typedef enum logic {
        PWM_IDLE = 1'b0,
        PWM_RUN  = 1'b1
    } pwm_state_e;

endpackage

`default_nettype wire

/* design/i2s_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module i2s_receiver (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      bclk,
    input  logic                      lrclk,
    input  logic                      sdata,
    output audio_pkg::stereo_sample_t pcm,
    output logic                      left_stb,
    output logic                      right_stb
);

    // Two-flop synchronizers for the bus lines
    logic [1:0] bclk_sync;
    logic [1:0] lrclk_sync;
    logic [1:0] sdata_sync;

    // Edge register stage
    logic bclk_prev;
    logic bclk_rise;
    logic lrclk_q;
    logic sdata_q;

    // Slot tracking
    logic [audio_pkg::SAMPLE_BITS-1:0] shift_q;
    logic [audio_pkg::SAMPLE_BITS-1:0] shift_next;
    audio_pkg::bit_cnt_t               bit_cnt;
    audio_pkg::bit_cnt_t               bit_idx;
    audio_pkg::channel_e               chan;
    audio_pkg::channel_e               new_chan;
    logic                              slot_start;

    ////////////////////////////////////////////////////////////////////////////
    // Synchronizers and bclk rising edge
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bclk_sync  <= '0;
            lrclk_sync <= '0;
            sdata_sync <= '0;
        end else begin
            bclk_sync  <= {bclk_sync[0], bclk};
            lrclk_sync <= {lrclk_sync[0], lrclk};
            sdata_sync <= {sdata_sync[0], sdata};
        end
    end

    // lrclk and sdata are delayed with the edge so they line up with bclk_rise
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bclk_prev <= 1'b0;
            bclk_rise <= 1'b0;
            lrclk_q   <= 1'b0;
            sdata_q   <= 1'b0;
        end else begin
            bclk_prev <= bclk_sync[1];
            bclk_rise <= bclk_sync[1] & ~bclk_prev;
            lrclk_q   <= lrclk_sync[1];
            sdata_q   <= sdata_sync[1];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Slot position and serial shift
    ////////////////////////////////////////////////////////////////////////////

    // An lrclk change makes the current bit the first one of a new slot
    always_comb begin
        new_chan   = audio_pkg::channel_e'(lrclk_q);
        slot_start = (new_chan != chan);
        bit_idx    = slot_start ? '0 : bit_cnt;
        shift_next = {shift_q[audio_pkg::SAMPLE_BITS-2:0], sdata_q};
    end

    // MSB first
    always_ff @(posedge clk) begin
        if (bclk_rise) begin
            shift_q <= shift_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_cnt <= '0;
            chan    <= audio_pkg::CH_LEFT;
        end else if (bclk_rise) begin
            chan <= new_chan;
            // Hold at SLOT_DONE so padding bits are ignored
            if (bit_idx != audio_pkg::SLOT_DONE) begin
                bit_cnt <= bit_idx + 1'b1;
            end else begin
                bit_cnt <= bit_idx;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Word capture and channel strobes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pcm       <= '0;
            left_stb  <= 1'b0;
            right_stb <= 1'b0;
        end else begin
            left_stb  <= 1'b0;
            right_stb <= 1'b0;
            if (bclk_rise && (bit_idx == audio_pkg::LAST_BIT)) begin
                if (new_chan == audio_pkg::CH_LEFT) begin
                    pcm.left <= audio_pkg::sample_t'(shift_next);
                    left_stb <= 1'b1;
                end else begin
                    pcm.right <= audio_pkg::sample_t'(shift_next);
                    right_stb <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/pwm_modulator.sv */
`timescale 1ns/1ps
`default_nettype none

module pwm_modulator (
    input  logic               clk,
    input  logic               rst_n,
    input  audio_pkg::sample_t sample,
    input  logic               load,
    output logic               pwm
);

    pwm_pkg::pwm_state_e state;
    pwm_pkg::duty_t      cnt;
    pwm_pkg::duty_t      new_duty;
    pwm_pkg::duty_t      pending_duty;
    pwm_pkg::duty_t      active_duty;
    logic                wrap;
    logic                take_duty;

    ////////////////////////////////////////////////////////////////////////////
    // Sample to duty
    ////////////////////////////////////////////////////////////////////////////

    // Offset binary: flip the sign bit of the top PWM_BITS bits
    assign new_duty = {~sample[audio_pkg::SAMPLE_BITS-1],
                       sample[audio_pkg::SAMPLE_BITS-2 -: pwm_pkg::PWM_BITS-1]};

    ////////////////////////////////////////////////////////////////////////////
    // State and period counter
    ////////////////////////////////////////////////////////////////////////////

    assign wrap = (state == pwm_pkg::PWM_RUN) && (cnt == pwm_pkg::CNT_LAST);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= pwm_pkg::PWM_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                pwm_pkg::PWM_IDLE: begin
                    // Counter stays at 0 so the first period starts clean
                    if (load) begin
                        state <= pwm_pkg::PWM_RUN;
                    end
                end
                pwm_pkg::PWM_RUN: begin
                    cnt <= wrap ? '0 : cnt + 1'b1;
                end
                default: begin
                    state <= pwm_pkg::PWM_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Duty registers
    ////////////////////////////////////////////////////////////////////////////

    // Active duty only changes between periods, never mid-period
    assign take_duty = ((state == pwm_pkg::PWM_IDLE) && load) || wrap;

    always_ff @(posedge clk) begin
        if (load) begin
            pending_duty <= new_duty;
        end
        // A load on the wrap cycle goes straight through
        if (take_duty) begin
            active_duty <= load ? new_duty : pending_duty;
        end
    end

    // High for the first active_duty counts of each period
    assign pwm = (state == pwm_pkg::PWM_RUN) && (cnt < active_duty);

endmodule

`default_nettype wire

/* design/i2s_pwm_top.sv */
`timescale 1ns/1ps
`default_nettype none

module i2s_pwm_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      bclk,
    input  logic                      lrclk,
    input  logic                      sdata,
    output audio_pkg::stereo_sample_t pcm,
    output logic                      left_stb,
    output logic                      right_stb,
    output logic                      pwm_left,
    output logic                      pwm_right
);

    ////////////////////////////////////////////////////////////////////////////
    // I2S receiver
    ////////////////////////////////////////////////////////////////////////////

    i2s_receiver u_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .bclk      (bclk),
        .lrclk     (lrclk),
        .sdata     (sdata),
        .pcm       (pcm),
        .left_stb  (left_stb),
        .right_stb (right_stb)
    );

    ////////////////////////////////////////////////////////////////////////////
    // One modulator per channel
    ////////////////////////////////////////////////////////////////////////////

    pwm_modulator u_pwm_left (
        .clk    (clk),
        .rst_n  (rst_n),
        .sample (pcm.left),
        .load   (left_stb),
        .pwm    (pwm_left)
    );

    pwm_modulator u_pwm_right (
        .clk    (clk),
        .rst_n  (rst_n),
        .sample (pcm.right),
        .load   (right_stb),
        .pwm    (pwm_right)
    );

endmodule

`default_nettype wire

/* dv/i2s_pwm_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module i2s_pwm_asserts (
    input logic                clk,
    input logic                rst_n,
    input logic                stb_a,
    input logic                stb_b,
    input logic                pwm,
    input pwm_pkg::pwm_state_e state
);

    // Left and right words never finish in the same cycle
    a_stb_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(stb_a && stb_b))
        else $error("Both strobes high in one cycle");

    a_stb_a_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        stb_a |=> !stb_a)
        else $error("Strobe A held for two cycles");

    a_stb_b_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        stb_b |=> !stb_b)
        else $error("Strobe B held for two cycles");

    a_idle_low: assert property (@(posedge clk) disable iff (!rst_n)
        (state == pwm_pkg::PWM_IDLE) |-> !pwm)
        else $error("PWM output high while idle");

    a_reset_clears: assert property (@(posedge clk)
        !rst_n |=> (!stb_a && !stb_b && !pwm))
        else $error("Outputs not low after a reset cycle");

endmodule

// Receiver has no PWM output, so that check is tied off
bind i2s_receiver i2s_pwm_asserts u_asserts (
    .clk   (clk),
    .rst_n (rst_n),
    .stb_a (left_stb),
    .stb_b (right_stb),
    .pwm   (1'b0),
    .state (pwm_pkg::PWM_IDLE)
);

bind pwm_modulator i2s_pwm_asserts u_asserts (
    .clk   (clk),
    .rst_n (rst_n),
    .stb_a (load),
    .stb_b (1'b0),
    .pwm   (pwm),
    .state (state)
);

`default_nettype wire

/* dv/tb_i2s_pwm.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_i2s_pwm;

    localparam int BCLK_HALF  = 4;
    localparam int WAIT_LIMIT = 2000;

    logic                      clk;
    logic                      rst_n;
    logic                      bclk;
    logic                      lrclk;
    logic                      sdata;
    audio_pkg::stereo_sample_t pcm;
    logic                      left_stb;
    logic                      right_stb;
    logic                      pwm_left;
    logic                      pwm_right;
    int                        seed;

    // Words seen on the strobes, and words sent, in order
    audio_pkg::sample_t  got_data[$];
    audio_pkg::channel_e got_chan[$];
    audio_pkg::sample_t  exp_data[$];
    audio_pkg::channel_e exp_chan[$];

    i2s_pwm_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .bclk      (bclk),
        .lrclk     (lrclk),
        .sdata     (sdata),
        .pcm       (pcm),
        .left_stb  (left_stb),
        .right_stb (right_stb),
        .pwm_left  (pwm_left),
        .pwm_right (pwm_right)
    );

    always #4 clk = ~clk;

    // Strobe monitor
    always @(posedge clk) begin
        if (rst_n && left_stb) begin
            got_data.push_back(pcm.left);
            got_chan.push_back(audio_pkg::CH_LEFT);
        end
        if (rst_n && right_stb) begin
            got_data.push_back(pcm.right);
            got_chan.push_back(audio_pkg::CH_RIGHT);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic tick(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "Stopped on first error");
    endtask

    task automatic check_sample(input audio_pkg::sample_t got, input audio_pkg::sample_t exp,
                                input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_duty(input pwm_pkg::duty_t got, input pwm_pkg::duty_t exp,
                              input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // I2S driver
    ////////////////////////////////////////////////////////////////////////////

    // lrclk and data change with bclk low, 8 clk cycles per bit
    task automatic send_bit(input logic lr, input logic d);
        bclk  = 1'b0;
        lrclk = lr;
        sdata = d;
        tick(BCLK_HALF);
        bclk = 1'b1;
        tick(BCLK_HALF);
    endtask

    task automatic send_word(input logic lr, input audio_pkg::sample_t word, input int slot_bits);
        int r;
        for (int i = 0; i < slot_bits; i++) begin
            r = $random(seed);
            if (i < audio_pkg::SAMPLE_BITS) begin
                send_bit(lr, word[audio_pkg::SAMPLE_BITS-1-i]);
            end else begin
                send_bit(lr, r[0]);
            end
        end
    endtask

    task automatic send_frame(input audio_pkg::sample_t left, input audio_pkg::sample_t right,
                              input int slot_bits);
        exp_data.push_back(left);
        exp_chan.push_back(audio_pkg::CH_LEFT);
        exp_data.push_back(right);
        exp_chan.push_back(audio_pkg::CH_RIGHT);
        send_word(1'b0, left, slot_bits);
        send_word(1'b1, right, slot_bits);
        bclk = 1'b0;
    endtask

    task automatic wait_captures();
        int n;
        n = 0;
        while (got_data.size() < exp_data.size()) begin
            if (n == WAIT_LIMIT) begin
                $display("Timeout: strobe for word %0d never came", got_data.size());
                abort_run();
            end
            tick(1);
            n++;
        end
    endtask

    task automatic check_captures();
        wait_captures();
        // One more bit time, so a repeated strobe would show up
        tick(2 * BCLK_HALF);
        if (got_data.size() != exp_data.size()) begin
            $display("Strobe count wrong: %0d words captured, %0d sent",
                     got_data.size(), exp_data.size());
            abort_run();
        end
        while (exp_data.size() > 0) begin
            check_level(got_chan.pop_front(), exp_chan.pop_front(), "channel order");
            check_sample(got_data.pop_front(), exp_data.pop_front(), "captured word");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        repeat (300) begin
            tick(1);
            check_level(left_stb, 1'b0, "left_stb");
            check_level(right_stb, 1'b0, "right_stb");
            check_level(pwm_left, 1'b0, "pwm_left");
            check_level(pwm_right, 1'b0, "pwm_right");
            check_sample(pcm.left, '0, "pcm.left");
            check_sample(pcm.right, '0, "pcm.right");
        end
    endtask

    task automatic test_single_frame();
        send_frame(24'h123456, 24'hA5C3E1, 24);
        check_captures();
    endtask

    // Trailing 8 bits of each 32-bit slot are random
    task automatic test_wide_slots();
        send_frame(24'h7E0181, 24'h80FF00, 32);
        check_captures();
    endtask

    task automatic test_random_frames();
        audio_pkg::sample_t l;
        audio_pkg::sample_t r;
        repeat (8) begin
            l = audio_pkg::sample_t'($random(seed));
            r = audio_pkg::sample_t'($random(seed));
            send_frame(l, r, 24);
        end
        check_captures();
    endtask

    // High cycles over one full period give the duty
    task automatic check_pwm(input audio_pkg::sample_t left, input audio_pkg::sample_t right,
                             input pwm_pkg::duty_t exp_left, input pwm_pkg::duty_t exp_right);
        int high_left;
        int high_right;
        high_left  = 0;
        high_right = 0;
        send_frame(left, right, 24);
        check_captures();
        tick(pwm_pkg::PWM_PERIOD);
        repeat (pwm_pkg::PWM_PERIOD) begin
            tick(1);
            high_left  += int'(pwm_left);
            high_right += int'(pwm_right);
        end
        if ((high_left >= pwm_pkg::PWM_PERIOD) || (high_right >= pwm_pkg::PWM_PERIOD)) begin
            $display("FAILED at %0t: a PWM output stayed high for a whole period", $time);
            abort_run();
        end
        check_duty(pwm_pkg::duty_t'(high_left), exp_left, "left duty");
        check_duty(pwm_pkg::duty_t'(high_right), exp_right, "right duty");
    endtask

    initial begin
        seed  = 8625;
        clk   = 1'b0;
        rst_n = 1'b0;
        bclk  = 1'b0;
        lrclk = 1'b0;
        sdata = 1'b0;
        tick(2);
        rst_n = 1'b1;

        test_reset();
        test_single_frame();
        test_wide_slots();
        test_random_frames();
        check_pwm(24'h800000, 24'h7FFFFF, 8'd0, 8'd255);
        check_pwm(24'h000000, 24'h800000, 8'd128, 8'd0);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
design/audio_pkg.sv
design/pwm_pkg.sv
design/i2s_receiver.sv
design/pwm_modulator.sv
design/i2s_pwm_top.sv
dv/i2s_pwm_asserts.sv
dv/tb_i2s_pwm.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the I2S to PWM testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_i2s_pwm -f sources.f -o tb_i2s_pwm &&
./obj_dir/tb_i2s_pwm || {
    echo "run_sim.sh: build or simulation returned an error"
    exit 1
}
